// File: Bender.yml
package:
  name: conv_engine

sources:
  - logic/conv_pkg.sv
  - logic/mem_bus_if.sv
  - logic/pixel_ram.sv
  - logic/mem_arbiter.sv
  - logic/mac_datapath.sv
  - logic/result_store.sv
  - logic/window_fetch.sv
  - logic/conv_control.sv
  - logic/conv_top.sv
  - target: test
    files:
      - bench/conv_tb.sv

// File: bench/conv_tb.sv
`default_nettype none
`timescale 1ns/1ps

module conv_tb;
    import conv_pkg::*;

    localparam int IMG_W    = 8;
    localparam int IMG_H    = 8;
    localparam int N_PIX    = IMG_W * IMG_H;
    localparam int OUT_BASE = IMG_W * IMG_H;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              busy;
    logic              finish;
    logic              kernel_we;
    logic [3:0]        kernel_idx;
    weight_t           kernel_data;
    logic              host_req;
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    pixel_t            host_wdata;
    logic              host_gnt;
    pixel_t            host_rdata;
    logic              host_rvalid;

    integer  seed;
    int      finish_count = 0;
    pixel_t  img [N_PIX];  // Model of the image region.
    weight_t kern [9];

    conv_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_conv_top (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .finish(finish),
        .kernel_we(kernel_we), .kernel_idx(kernel_idx), .kernel_data(kernel_data),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_gnt(host_gnt), .host_rdata(host_rdata),
        .host_rvalid(host_rvalid)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (rst_n && finish)
            finish_count <= finish_count + 1;
    end

    // --------------------------------------------------
    // Checking and model
    // --------------------------------------------------
    task automatic check_value(input string name, input int exp, input int got);
        assert (exp == got)
        else
        begin
            $display("Error in %s: expected %0d, actual %0d", name, exp, got);
            $display("Test failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("Timed out waiting for %s.", what);
        $display("Test failed");
        $fatal(1, "The DUT stopped responding.");
    endtask

    // Clamped 3x3 dot product for the window at row r, column c.
    function automatic int expected_pixel(input int r, input int c);
        int sum;
        sum = 0;
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                sum += int'(img[(r + i) * IMG_W + c + j]) * int'(kern[i * 3 + j]);
        if (sum < 0)
            return 0;
        else if (sum > 255)
            return 255;
        return sum;
    endfunction

    // --------------------------------------------------
    // Host port
    // --------------------------------------------------
    task automatic wait_host_gnt();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!host_gnt)
        begin
            cycles++;
            if (cycles > 50)
                timeout_abort("host_gnt");
            @(posedge clk);
        end
    endtask

    task automatic write_host(input int addr, input pixel_t data);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= 1'b1;
        host_addr  <= ADDR_W'(addr);
        host_wdata <= data;
        wait_host_gnt();
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic read_host(input int addr, output pixel_t data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        host_req  <= 1'b1;
        host_we   <= 1'b0;
        host_addr <= ADDR_W'(addr);
        wait_host_gnt();
        host_req <= 1'b0;
        @(posedge clk);
        while (!host_rvalid)
        begin
            cycles++;
            if (cycles > 50)
                timeout_abort("host_rvalid");
            @(posedge clk);
        end
        data = host_rdata;
    endtask

    // Mode 0 gives random pixels, mode 1 bright ones.
    task automatic write_image(input int mode);
        for (int a = 0; a < N_PIX; a++)
        begin
            if (mode == 0)
                img[a] = pixel_t'($random(seed));
            else
                img[a] = 8'd192 + pixel_t'({$random(seed)} % 64);
            write_host(a, img[a]);
        end
    endtask

    // Mode 0 gives random weights, mode 1 all 127, mode 2 all -128.
    task automatic load_kernel(input int mode);
        for (int k = 0; k < 9; k++)
        begin
            if (mode == 0)
                kern[k] = weight_t'($random(seed));
            else if (mode == 1)
                kern[k] = 8'sd127;
            else
                kern[k] = -8'sd128;
            @(posedge clk);
            kernel_we   <= 1'b1;
            kernel_idx  <= 4'(k);
            kernel_data <= kern[k];
        end
        @(posedge clk);
        kernel_we <= 1'b0;
    endtask

    // --------------------------------------------------
    // Convolution runs
    // --------------------------------------------------
    task automatic run_conv(input bit traffic);
        int     target;
        int     cycles;
        int     a;
        pixel_t data;
        target = finish_count + 1;
        cycles = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (finish_count < target)
        begin
            cycles++;
            if (cycles > 5000)
                timeout_abort("finish");
            if (traffic)
            begin
                a = {$random(seed)} % N_PIX;
                read_host(a, data);
                check_value("concurrent read", img[a], data);
            end
            else
                @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_value("finish pulses", target, finish_count); // One pulse per run.
        check_value("busy after run", 0, busy);
    endtask

    // A negative fixed value means the model decides.
    task automatic check_outputs(input string name, input int fixed);
        pixel_t data;
        int     exp;
        for (int r = 0; r < IMG_H - 2; r++)
            for (int c = 0; c < IMG_W - 2; c++)
            begin
                read_host(OUT_BASE + r * (IMG_W - 2) + c, data);
                exp = (fixed < 0) ? expected_pixel(r, c) : fixed;
                check_value(name, exp, data);
            end
    endtask

    initial
    begin
        int     a;
        pixel_t data;
        seed        = 99683;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        kernel_we   = 1'b0;
        kernel_idx  = '0;
        kernel_data = '0;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_value("reset busy", 0, busy);
        check_value("reset finish", 0, finish);
        check_value("reset host_gnt", 0, host_gnt);
        check_value("reset host_rvalid", 0, host_rvalid);

        // Full image first, then scattered overwrites.
        write_image(0);
        repeat (32)
        begin
            a      = {$random(seed)} % N_PIX;
            img[a] = pixel_t'($random(seed));
            write_host(a, img[a]);
        end
        for (int i = 0; i < N_PIX; i++)
        begin
            read_host(i, data);
            check_value("host read-back", img[i], data);
        end

        load_kernel(0);
        run_conv(1'b0);
        check_outputs("full convolution", -1);

        write_image(1);
        load_kernel(1);
        run_conv(1'b0);
        check_outputs("clamp high", 255);
        load_kernel(2);
        run_conv(1'b0);
        check_outputs("clamp low", 0);

        write_image(0);
        load_kernel(0);
        run_conv(1'b1);
        check_outputs("concurrent traffic", -1);

        load_kernel(0);
        run_conv(1'b0);
        check_outputs("rerun", -1);
        check_value("total finish pulses", 5, finish_count);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/conv_pkg.sv
logic/mem_bus_if.sv
logic/pixel_ram.sv
logic/mem_arbiter.sv
logic/mac_datapath.sv
logic/result_store.sv
logic/window_fetch.sv
logic/conv_control.sv
logic/conv_top.sv
bench/conv_tb.sv

// File: logic/conv_control.sv
`default_nettype none
`timescale 1ns/1ps

module conv_control (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                conv,
    input  wire                load_done,
    input  wire                done,
    input  wire                store_done,
    output logic               addr_gen,
    output logic               load,
    output conv_pkg::mac_row_e mux_sel,
    output logic               add,
    output logic               counter_enable,
    output logic               flush_acc,
    output logic               store,
    output logic               busy,
    output logic               finish
);
    import conv_pkg::*;

    conv_state_e state;
    conv_state_e next_state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    // --------------------------------------------------
    // Next state and strobes
    // --------------------------------------------------
    always_comb
    begin
        next_state     = state;
        addr_gen       = 1'b0;
        flush_acc      = 1'b0;
        load           = 1'b0;
        mux_sel        = ROW_NONE;
        add            = 1'b0;
        store          = 1'b0;
        counter_enable = 1'b0;
        finish         = 1'b0;

        case (state)
            IDLE:
            begin
                if (conv)
                    next_state = ADDR;
            end
            ADDR:
            begin
                addr_gen   = 1'b1;
                flush_acc  = 1'b1; // Fresh accumulator for every window.
                next_state = LOAD;
            end
            LOAD:
            begin
                load = 1'b1;
                if (load_done)
                    next_state = MAC0;
            end
            MAC0:
            begin
                add        = 1'b1;
                mux_sel    = ROW_0;
                next_state = MAC1;
            end
            MAC1:
            begin
                add        = 1'b1;
                mux_sel    = ROW_1;
                next_state = MAC2;
            end
            MAC2:
            begin
                add        = 1'b1;
                mux_sel    = ROW_2;
                next_state = STORE;
            end
            STORE:
            begin
                store = 1'b1; // Held until the write is granted.
                if (store_done)
                    next_state = UPDATE_COUNTERS;
            end
            UPDATE_COUNTERS:
            begin
                counter_enable = 1'b1;
                next_state     = CHECK_DONE;
            end
            CHECK_DONE:
            begin
                finish     = done;
                next_state = done ? IDLE : ADDR;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    assign busy = (state != IDLE);

    a_load_store_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load && store));

    a_row_only_on_add: assert property (@(posedge clk) disable iff (!rst_n)
        !add |-> (mux_sel == ROW_NONE));

endmodule

`default_nettype wire

// File: logic/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int ADDR_W = 8;

    typedef logic [7:0] pixel_t;
    typedef logic signed [7:0] weight_t;
    typedef logic signed [19:0] acc_t; // Nine 9x8 products fit with room to spare.

    typedef enum logic [3:0] {
        IDLE,
        ADDR,
        LOAD,
        MAC0,
        MAC1,
        MAC2,
        STORE,
        UPDATE_COUNTERS,
        CHECK_DONE
    } conv_state_e;

    // Selects which window row feeds the three multipliers.
    typedef enum logic [1:0] {
        ROW_NONE,
        ROW_0,
        ROW_1,
        ROW_2
    } mac_row_e;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_HOST,
        OWN_STORE,
        OWN_FETCH
    } bus_owner_e;

endpackage

`default_nettype wire

// File: logic/conv_top.sv
`default_nettype none
`timescale 1ns/1ps

module conv_top #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    output logic                         busy,
    output logic                         finish,
    input  wire                          kernel_we,
    input  wire [3:0]                    kernel_idx,
    input  wire conv_pkg::weight_t       kernel_data,
    input  wire                          host_req,
    input  wire                          host_we,
    input  wire [conv_pkg::ADDR_W-1:0]   host_addr,
    input  wire conv_pkg::pixel_t        host_wdata,
    output logic                         host_gnt,
    output conv_pkg::pixel_t             host_rdata,
    output logic                         host_rvalid
);
    import conv_pkg::*;

    logic              addr_gen;
    logic              load;
    logic              add;
    logic              counter_enable;
    logic              flush_acc;
    logic              store;
    logic              load_done;
    logic              done;
    logic              store_done;
    mac_row_e          mux_sel;
    pixel_t [8:0]      win_pixels;
    pixel_t            result;
    logic              ram_en;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    pixel_t            ram_wdata;
    pixel_t            ram_rdata;

    mem_bus_if fetch_bus ();
    mem_bus_if store_bus ();

    // --------------------------------------------------
    // Sequencer and datapath
    // --------------------------------------------------
    conv_control i_conv_control (
        .clk(clk), .rst_n(rst_n), .conv(start), .load_done(load_done), .done(done),
        .store_done(store_done), .addr_gen(addr_gen), .load(load), .mux_sel(mux_sel),
        .add(add), .counter_enable(counter_enable), .flush_acc(flush_acc),
        .store(store), .busy(busy), .finish(finish)
    );

    window_fetch #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_window_fetch (
        .clk(clk), .rst_n(rst_n), .addr_gen(addr_gen), .load(load),
        .counter_enable(counter_enable), .load_done(load_done), .done(done),
        .win_pixels(win_pixels), .bus(fetch_bus.requester)
    );

    mac_datapath i_mac_datapath (
        .clk(clk), .rst_n(rst_n), .kernel_we(kernel_we), .kernel_idx(kernel_idx),
        .kernel_data(kernel_data), .flush_acc(flush_acc), .add(add),
        .mux_sel(mux_sel), .win_pixels(win_pixels), .result(result)
    );

    result_store #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_result_store (
        .clk(clk), .rst_n(rst_n), .store(store), .counter_enable(counter_enable),
        .result(result), .store_done(store_done), .bus(store_bus.requester)
    );

    // --------------------------------------------------
    // Shared memory
    // --------------------------------------------------
    mem_arbiter i_mem_arbiter (
        .clk(clk), .rst_n(rst_n), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_gnt(host_gnt),
        .host_rdata(host_rdata), .host_rvalid(host_rvalid),
        .store_bus(store_bus.arbiter), .fetch_bus(fetch_bus.arbiter),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    pixel_ram i_pixel_ram (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// File: logic/mac_datapath.sv
`default_nettype none
`timescale 1ns/1ps

module mac_datapath (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          kernel_we,
    input  wire [3:0]                    kernel_idx,
    input  wire conv_pkg::weight_t       kernel_data,
    input  wire                          flush_acc,
    input  wire                          add,
    input  wire conv_pkg::mac_row_e      mux_sel,
    input  wire conv_pkg::pixel_t [8:0]  win_pixels,
    output conv_pkg::pixel_t             result
);
    import conv_pkg::*;

    weight_t    kernel [9];
    acc_t       acc;
    acc_t       row_sum;
    logic [3:0] row_base;

    always_ff @(posedge clk)
    begin
        if (kernel_we && (kernel_idx < 4'd9))
            kernel[kernel_idx] <= kernel_data;
    end

    // --------------------------------------------------
    // One window row per add
    // --------------------------------------------------
    always_comb
    begin
        row_sum = '0;
        case (mux_sel)
            ROW_1:   row_base = 4'd3;
            ROW_2:   row_base = 4'd6;
            default: row_base = 4'd0;
        endcase
        if (mux_sel != ROW_NONE)
        begin
            for (int k = 0; k < 3; k++)
                row_sum = row_sum + $signed({1'b0, win_pixels[row_base + k]})
                                    * kernel[row_base + k]; // Pixel is zero-extended.
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            acc <= '0;
        else if (flush_acc)
            acc <= '0;
        else if (add)
            acc <= acc + row_sum;
    end

    always_comb
    begin
        if (acc < 0)
            result = '0;
        else if (acc > 255)
            result = 8'hff;
        else
            result = acc[7:0];
    end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          host_req,
    input  wire                          host_we,
    input  wire [conv_pkg::ADDR_W-1:0]   host_addr,
    input  wire conv_pkg::pixel_t        host_wdata,
    output logic                         host_gnt,
    output conv_pkg::pixel_t             host_rdata,
    output logic                         host_rvalid,
    mem_bus_if.arbiter                   store_bus,
    mem_bus_if.arbiter                   fetch_bus,
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [conv_pkg::ADDR_W-1:0]  ram_addr,
    output conv_pkg::pixel_t             ram_wdata,
    input  wire conv_pkg::pixel_t        ram_rdata
);
    import conv_pkg::*;

    bus_owner_e rd_owner; // Who gets the read data next cycle.

    assign host_gnt      = host_req; // Host is never stalled.
    assign store_bus.gnt = store_bus.req && !host_req;
    assign fetch_bus.gnt = fetch_bus.req && !host_req && !store_bus.req;

    always_comb
    begin
        ram_en    = 1'b1;
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        if (host_gnt)
        begin
            ram_we    = host_we;
            ram_addr  = host_addr;
            ram_wdata = host_wdata;
        end
        else if (store_bus.gnt)
        begin
            ram_we    = store_bus.we;
            ram_addr  = store_bus.addr;
            ram_wdata = store_bus.wdata;
        end
        else if (fetch_bus.gnt)
        begin
            ram_we    = fetch_bus.we;
            ram_addr  = fetch_bus.addr;
            ram_wdata = fetch_bus.wdata;
        end
        else
            ram_en = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_owner <= OWN_NONE;
        else if (host_gnt && !host_we)
            rd_owner <= OWN_HOST;
        else if (store_bus.gnt && !store_bus.we)
            rd_owner <= OWN_STORE;
        else if (fetch_bus.gnt && !fetch_bus.we)
            rd_owner <= OWN_FETCH;
        else
            rd_owner <= OWN_NONE;
    end

    assign host_rvalid      = (rd_owner == OWN_HOST);
    assign store_bus.rvalid = (rd_owner == OWN_STORE);
    assign fetch_bus.rvalid = (rd_owner == OWN_FETCH);
    assign host_rdata       = ram_rdata;
    assign store_bus.rdata  = ram_rdata;
    assign fetch_bus.rdata  = ram_rdata;

    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({host_gnt, store_bus.gnt, fetch_bus.gnt}));

endmodule

`default_nettype wire

// File: logic/mem_bus_if.sv
`default_nettype none
`timescale 1ns/1ps

interface mem_bus_if;
    import conv_pkg::*;

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    pixel_t            wdata;
    logic              gnt;   // Transfer happens in the cycle req and gnt are both high.
    pixel_t            rdata;
    logic              rvalid; // One cycle after a read grant.

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

// File: logic/pixel_ram.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_ram (
    input  wire                          clk,
    input  wire                          en,
    input  wire                          we,
    input  wire [conv_pkg::ADDR_W-1:0]   addr,
    input  wire conv_pkg::pixel_t        wdata,
    output conv_pkg::pixel_t             rdata
);
    import conv_pkg::*;

    pixel_t mem [2**ADDR_W];

    // Registered read, one cycle of latency.
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/result_store.sv
`default_nettype none
`timescale 1ns/1ps

module result_store #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   store,
    input  wire                   counter_enable,
    input  wire conv_pkg::pixel_t result,
    output logic                  store_done,
    mem_bus_if.requester          bus
);
    import conv_pkg::*;

    localparam int OUT_BASE = IMG_W * IMG_H;
    localparam int N_OUT    = (IMG_W - 2) * (IMG_H - 2);

    logic [ADDR_W-1:0] out_idx;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_idx <= '0;
        else if (counter_enable)
            out_idx <= (out_idx == ADDR_W'(N_OUT - 1)) ? '0 : out_idx + 1'b1;
    end

    assign bus.req    = store;
    assign bus.we     = 1'b1;
    assign bus.addr   = ADDR_W'(OUT_BASE) + out_idx;
    assign bus.wdata  = result;
    assign store_done = store && bus.gnt; // High in the write-grant cycle.

endmodule

`default_nettype wire

// File: logic/window_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module window_fetch #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     addr_gen,
    input  wire                     load,
    input  wire                     counter_enable,
    output logic                    load_done,
    output logic                    done,
    output conv_pkg::pixel_t [8:0]  win_pixels,
    mem_bus_if.requester            bus
);
    import conv_pkg::*;

    localparam int OUT_BASE = IMG_W * IMG_H;

    logic [ADDR_W-1:0] col;
    logic [ADDR_W-1:0] row;
    logic [ADDR_W-1:0] rd_addr;
    logic [1:0]        rd_col;   // Column of the next read inside the window.
    logic [3:0]        issued;
    logic [3:0]        received;

    // --------------------------------------------------
    // Window position
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            col  <= '0;
            row  <= '0;
            done <= 1'b0;
        end
        else if (counter_enable)
        begin
            if (col == ADDR_W'(IMG_W - 3))
            begin
                col <= '0;
                if (row == ADDR_W'(IMG_H - 3))
                begin
                    row  <= '0;
                    done <= 1'b1; // Stepped past the last window.
                end
                else
                    row <= row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
        else if (addr_gen)
            done <= 1'b0;
    end

    // Nine reads in row-major order starting at the window base.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_addr <= '0;
            rd_col  <= '0;
            issued  <= '0;
        end
        else if (addr_gen)
        begin
            rd_addr <= row * ADDR_W'(IMG_W) + col;
            rd_col  <= '0;
            issued  <= '0;
        end
        else if (bus.gnt)
        begin
            issued <= issued + 1'b1;
            if (rd_col == 2'd2)
            begin
                rd_col  <= '0;
                rd_addr <= rd_addr + ADDR_W'(IMG_W - 2);
            end
            else
            begin
                rd_col  <= rd_col + 1'b1;
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    assign bus.req   = load && (issued != 4'd9);
    assign bus.we    = 1'b0;
    assign bus.addr  = rd_addr;
    assign bus.wdata = '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            received  <= '0;
            load_done <= 1'b0;
        end
        else
        begin
            load_done <= bus.rvalid && (received == 4'd8);
            if (addr_gen)
                received <= '0;
            else if (bus.rvalid)
                received <= received + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.rvalid)
            win_pixels[received] <= bus.rdata;
    end

    a_req_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req |-> load);

    // Window reads never reach into the output region.
    a_read_in_image: assert property (@(posedge clk) disable iff (!rst_n)
        bus.gnt |-> (bus.addr < ADDR_W'(OUT_BASE)));

endmodule

`default_nettype wire
